/* pit_pkg.sv */
// Shared widths, address map, field codes and control word layout for the interval timer
package pit_pkg;

	// Sizes
	localparam int unsigned NUM_CHANNELS = 3;
	localparam int unsigned DATA_W       = 8;
	localparam int unsigned COUNT_W      = 16;
	localparam int unsigned ADDR_W       = 2;

	// Address 0 to 2 pick a channel, 3 is the control word
	localparam logic [ADDR_W-1:0] ADDR_CTRL = 2'd3;

	// Read/write format field
	localparam logic [1:0] RW_LATCH = 2'd0;
	localparam logic [1:0] RW_LSB   = 2'd1;
	localparam logic [1:0] RW_MSB   = 2'd2;
	localparam logic [1:0] RW_BOTH  = 2'd3;

	// Supported counting modes
	localparam logic [2:0] MODE_TERM   = 3'd0;
	localparam logic [2:0] MODE_RATE   = 3'd2;
	localparam logic [2:0] MODE_SQUARE = 3'd3;

	// Control byte, seen either as a mode command or as a counter latch command.
	// Both views share the select field in the top two bits.
	typedef union packed {
		struct packed {
			logic [1:0] select;
			logic [1:0] rw;
			logic [2:0] mode;
			logic       bcd;
		} mode_cmd;
		struct packed {
			logic [1:0] select;
			logic [1:0] latch;
			logic [3:0] unused;
		} latch_cmd;
	} ctrl_word_u;

endpackage

/* pit_bus_decode.sv */
// Host bus decoder that turns strobes and address into registered per-channel pulses
`timescale 1ns/1ps

module pit_bus_decode
	import pit_pkg::*;
(
	input  logic                    ZCLK,
	input  logic                    rst_n,
	input  logic                    cs_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic [ADDR_W-1:0]       addr,
	input  logic [DATA_W-1:0]       d_in,
	output logic [NUM_CHANNELS-1:0] ctrl_wr,
	output logic [NUM_CHANNELS-1:0] latch_wr,
	output logic [NUM_CHANNELS-1:0] count_wr,
	output logic [NUM_CHANNELS-1:0] rd_strobe,
	output ctrl_word_u              ctrl_word,
	output logic [DATA_W-1:0]       wr_data,
	output logic [NUM_CHANNELS-1:0] rd_sel
);

	logic                    wr_acc;
	logic                    rd_acc;
	logic                    ctrl_acc;
	ctrl_word_u              cw_in;
	logic [NUM_CHANNELS-1:0] ctrl_wr_d;
	logic [NUM_CHANNELS-1:0] latch_wr_d;
	logic [NUM_CHANNELS-1:0] count_wr_d;
	logic [NUM_CHANNELS-1:0] rd_strobe_d;
	logic [DATA_W-1:0]       data_q;

	// One access per cycle, chip select plus exactly one strobe
	assign wr_acc   = !cs_n && !wr_n && rd_n;
	assign rd_acc   = !cs_n && !rd_n && wr_n;
	assign ctrl_acc = wr_acc && (addr == ADDR_CTRL);
	assign cw_in    = d_in;

	always_comb begin
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			// Mode command: rw field nonzero
			ctrl_wr_d[i]   = ctrl_acc && (cw_in.mode_cmd.select == ADDR_W'(i))
				&& (cw_in.mode_cmd.rw != RW_LATCH);
			// Latch command: same field read as latch code
			latch_wr_d[i]  = ctrl_acc && (cw_in.latch_cmd.select == ADDR_W'(i))
				&& (cw_in.latch_cmd.latch == RW_LATCH);
			count_wr_d[i]  = wr_acc && (addr == ADDR_W'(i));
			rd_strobe_d[i] = rd_acc && (addr == ADDR_W'(i));
		end
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_wr   <= '0;
			latch_wr  <= '0;
			count_wr  <= '0;
			rd_strobe <= '0;
		end else begin
			ctrl_wr   <= ctrl_wr_d;
			latch_wr  <= latch_wr_d;
			count_wr  <= count_wr_d;
			rd_strobe <= rd_strobe_d;
		end
	end

	// Write byte follows its strobe by one cycle
	always_ff @(posedge ZCLK) begin
		if (wr_acc) begin
			data_q <= d_in;
		end
	end

	assign ctrl_word = data_q;
	assign wr_data   = data_q;
	assign rd_sel    = rd_strobe;

	a_one_strobe: assert property (@(posedge ZCLK) disable iff (!rst_n)
		!cs_n |-> (rd_n || wr_n));

endmodule

/* pit_channel.sv */
// One timer channel with count loading, down counter, output waveform and count latch
`timescale 1ns/1ps

module pit_channel
	import pit_pkg::*;
(
	input  logic              ZCLK,
	input  logic              rst_n,
	input  logic              ctrl_wr,
	input  logic              latch_wr,
	input  logic              count_wr,
	input  logic              rd_strobe,
	input  ctrl_word_u        ctrl_word,
	input  logic [DATA_W-1:0] wr_data,
	input  logic              count_clk,
	input  logic              gate,
	output logic              out,
	output logic [DATA_W-1:0] rd_byte
);

	logic [2:0]         mode_q;
	logic [1:0]         rw_q;
	logic               wr_msb_q;
	logic               rd_msb_q;
	logic               load_pend_q;
	logic               armed_q;
	logic               latched_q;
	logic [DATA_W-1:0]  lsb_hold_q;
	logic [COUNT_W-1:0] cr_q;
	logic [COUNT_W-1:0] count_q;
	logic [COUNT_W-1:0] count_dec;
	logic [COUNT_W-1:0] latch_q;
	logic [COUNT_W-1:0] rd_src;
	logic [COUNT_W:0]   n_ext;
	logic [COUNT_W:0]   half_n;
	logic               clk_meta;
	logic               clk_sync;
	logic               clk_prev;
	logic               gate_meta;
	logic               gate_s;
	logic               cnt_edge;
	logic               periodic;
	logic               ctrl_periodic;
	logic               read_done;

	// Count clock and gate share the same two-stage sync so they stay aligned
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			clk_meta  <= 1'b0;
			clk_sync  <= 1'b0;
			clk_prev  <= 1'b0;
			gate_meta <= 1'b0;
			gate_s    <= 1'b0;
		end else begin
			clk_meta  <= count_clk;
			clk_sync  <= clk_meta;
			clk_prev  <= clk_sync;
			gate_meta <= gate;
			gate_s    <= gate_meta;
		end
	end

	assign cnt_edge      = clk_sync && !clk_prev;
	assign periodic      = (mode_q == MODE_RATE) || (mode_q == MODE_SQUARE);
	assign ctrl_periodic = (ctrl_word.mode_cmd.mode == MODE_RATE)
		|| (ctrl_word.mode_cmd.mode == MODE_SQUARE);
	assign count_dec     = count_q - 1'b1;

	// A count of zero stands for 65536
	assign n_ext  = {(cr_q == '0), cr_q};
	assign half_n = n_ext >> 1;

	// Control word and count write sequencing
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			mode_q      <= MODE_TERM;
			rw_q        <= RW_LATCH;
			wr_msb_q    <= 1'b0;
			load_pend_q <= 1'b0;
		end else if (ctrl_wr) begin
			mode_q      <= ctrl_word.mode_cmd.mode;
			rw_q        <= ctrl_word.mode_cmd.rw;
			wr_msb_q    <= 1'b0;
			load_pend_q <= 1'b0;
		end else begin
			if (cnt_edge) begin
				load_pend_q <= 1'b0;
			end
			// Completed count wins over the load of an older one
			if (count_wr) begin
				if (rw_q == RW_BOTH) begin
					wr_msb_q <= !wr_msb_q;
					if (wr_msb_q) begin
						load_pend_q <= 1'b1;
					end
				end else if (rw_q != RW_LATCH) begin
					load_pend_q <= 1'b1;
				end
			end
		end
	end

	// Count register, the other byte is zero in single byte formats
	always_ff @(posedge ZCLK) begin
		if (count_wr) begin
			if (rw_q == RW_LSB) begin
				cr_q <= {{DATA_W{1'b0}}, wr_data};
			end else if (rw_q == RW_MSB) begin
				cr_q <= {wr_data, {DATA_W{1'b0}}};
			end else if (rw_q == RW_BOTH) begin
				if (wr_msb_q) begin
					cr_q <= {wr_data, lsb_hold_q};
				end else begin
					lsb_hold_q <= wr_data;
				end
			end
		end
	end

	// Down counter and output waveform
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
			armed_q <= 1'b0;
			out     <= 1'b0;
		end else if (ctrl_wr) begin
			armed_q <= 1'b0;
			out     <= ctrl_periodic;
		end else if (cnt_edge && load_pend_q) begin
			// Load ignores the gate level
			count_q <= cr_q;
			armed_q <= 1'b1;
			if (periodic) begin
				out <= 1'b1;
			end
		end else if (cnt_edge && armed_q && gate_s) begin
			if (periodic && (count_q == COUNT_W'(1))) begin
				count_q <= cr_q;
				out     <= 1'b1;
			end else begin
				count_q <= count_dec;
				if (mode_q == MODE_RATE) begin
					// Low for the single period at count 1
					out <= (count_dec != COUNT_W'(1));
				end else if (mode_q == MODE_SQUARE) begin
					out <= ({1'b0, count_dec} > half_n);
				end else if (count_dec == '0) begin
					out <= 1'b1;
				end
			end
		end else if (periodic && !gate_s) begin
			out <= 1'b1;
		end
	end

	// Latch holds until read out completely
	assign read_done = (rw_q != RW_BOTH) || rd_msb_q;

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			latched_q <= 1'b0;
			rd_msb_q  <= 1'b0;
		end else if (ctrl_wr) begin
			latched_q <= 1'b0;
			rd_msb_q  <= 1'b0;
		end else begin
			if (rd_strobe) begin
				if (rw_q == RW_BOTH) begin
					rd_msb_q <= !rd_msb_q;
				end
				if (read_done) begin
					latched_q <= 1'b0;
				end
			end
			if (latch_wr && !latched_q) begin
				latched_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge ZCLK) begin
		if (latch_wr && !latched_q) begin
			latch_q <= count_q;
		end
	end

	assign rd_src = latched_q ? latch_q : count_q;

	always_comb begin
		case (rw_q)
			RW_MSB:  rd_byte = rd_src[COUNT_W-1 -: DATA_W];
			RW_BOTH: rd_byte = rd_msb_q ? rd_src[COUNT_W-1 -: DATA_W] : rd_src[DATA_W-1:0];
			default: rd_byte = rd_src[DATA_W-1:0];
		endcase
	end

	a_count_on_edge: assert property (@(posedge ZCLK) disable iff (!rst_n)
		!cnt_edge |=> $stable(count_q));

	a_gate_holds_out: assert property (@(posedge ZCLK) disable iff (!rst_n)
		periodic && !gate_s && !ctrl_wr |=> out);

endmodule

/* pit_read_collect.sv */
// Read data collector that registers the addressed channel's byte onto the host bus
`timescale 1ns/1ps

module pit_read_collect
	import pit_pkg::*;
(
	input  logic                           ZCLK,
	input  logic                           rst_n,
	input  logic [NUM_CHANNELS-1:0]        rd_sel,
	input  logic [NUM_CHANNELS*DATA_W-1:0] rd_byte,
	output logic [DATA_W-1:0]              d_out
);

	logic [DATA_W-1:0] sel_byte;
	logic              rd_any;

	assign rd_any = |rd_sel;

	// One-hot select, so an OR of the gated bytes is enough
	always_comb begin
		sel_byte = '0;
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			if (rd_sel[i]) begin
				sel_byte = sel_byte | rd_byte[i*DATA_W +: DATA_W];
			end
		end
	end

	// Holds the last read byte until the next read
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			d_out <= '0;
		end else if (rd_any) begin
			d_out <= sel_byte;
		end
	end

	a_sel_onehot: assert property (@(posedge ZCLK) disable iff (!rst_n)
		$onehot0(rd_sel));

endmodule

/* pit_top.sv */
// Three-channel programmable interval timer with a byte-wide host bus
`timescale 1ns/1ps

module pit_top
	import pit_pkg::*;
(
	input  logic                    ZCLK,
	input  logic                    rst_n,
	input  logic                    cs_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic [ADDR_W-1:0]       addr,
	input  logic [DATA_W-1:0]       d_in,
	input  logic [NUM_CHANNELS-1:0] count_clk,
	input  logic [NUM_CHANNELS-1:0] gate,
	output logic [DATA_W-1:0]       d_out,
	output logic [NUM_CHANNELS-1:0] out
);

	logic [NUM_CHANNELS-1:0]        ctrl_wr;
	logic [NUM_CHANNELS-1:0]        latch_wr;
	logic [NUM_CHANNELS-1:0]        count_wr;
	logic [NUM_CHANNELS-1:0]        rd_strobe;
	logic [NUM_CHANNELS-1:0]        rd_sel;
	ctrl_word_u                     ctrl_word;
	logic [DATA_W-1:0]              wr_data;
	logic [NUM_CHANNELS*DATA_W-1:0] rd_byte;

	pit_bus_decode u_decode (
		.ZCLK      (ZCLK),
		.rst_n     (rst_n),
		.cs_n      (cs_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.addr      (addr),
		.d_in      (d_in),
		.ctrl_wr   (ctrl_wr),
		.latch_wr  (latch_wr),
		.count_wr  (count_wr),
		.rd_strobe (rd_strobe),
		.ctrl_word (ctrl_word),
		.wr_data   (wr_data),
		.rd_sel    (rd_sel)
	);

	// Identical channels, each with its own pins and read byte lane
	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
		pit_channel u_channel (
			.ZCLK      (ZCLK),
			.rst_n     (rst_n),
			.ctrl_wr   (ctrl_wr[i]),
			.latch_wr  (latch_wr[i]),
			.count_wr  (count_wr[i]),
			.rd_strobe (rd_strobe[i]),
			.ctrl_word (ctrl_word),
			.wr_data   (wr_data),
			.count_clk (count_clk[i]),
			.gate      (gate[i]),
			.out       (out[i]),
			.rd_byte   (rd_byte[i*DATA_W +: DATA_W])
		);
	end

	pit_read_collect u_collect (
		.ZCLK    (ZCLK),
		.rst_n   (rst_n),
		.rd_sel  (rd_sel),
		.rd_byte (rd_byte),
		.d_out   (d_out)
	);

endmodule

/* tb_pit_tasks.svh */
// Bus access, count clock, output measurement and compare tasks for the timer testbench

// One-cycle host write, called and returning 1 ns after a clock edge
task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] data);
	cs_n = 1'b0;
	wr_n = 1'b0;
	addr = a;
	d_in = data;
	@(posedge ZCLK);
	#1;
	cs_n = 1'b1;
	wr_n = 1'b1;
endtask

// d_out is valid two cycles after the read access
task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] data);
	cs_n = 1'b0;
	rd_n = 1'b0;
	addr = a;
	@(posedge ZCLK);
	#1;
	cs_n = 1'b1;
	rd_n = 1'b1;
	@(posedge ZCLK);
	#1;
	data = d_out;
endtask

// Control byte is select, rw, mode, bcd from the top bit down
task automatic write_control(input logic [1:0] ch, input logic [2:0] mode, input logic [1:0] rw);
	bus_write(ADDR_CTRL, {ch, rw, mode, 1'b0});
endtask

task automatic latch_count(input logic [1:0] ch);
	bus_write(ADDR_CTRL, {ch, RW_LATCH, 4'b0000});
endtask

task automatic write_count(input logic [1:0] ch, input logic [1:0] rw,
	input logic [COUNT_W-1:0] n);
	if (rw == RW_MSB) begin
		bus_write(ch, n[15:8]);
	end else begin
		bus_write(ch, n[7:0]);
		if (rw == RW_BOTH) begin
			bus_write(ch, n[15:8]);
		end
	end
endtask

task automatic pulse_count_clk(input int ch);
	count_clk[ch] = 1'b1;
	repeat (6) @(posedge ZCLK);
	#1;
	count_clk[ch] = 1'b0;
	repeat (6) @(posedge ZCLK);
	#1;
endtask

task automatic wait_out_level(input int ch, input logic level, input int max_cycles);
	int cycles;
	cycles = 0;
	while (out[ch] !== level && cycles < max_cycles) begin
		@(posedge ZCLK);
		#1;
		cycles++;
	end
	if (out[ch] !== level) begin
		n_timeout++;
		$display("Timeout at %0t ns: out[%0d] did not go to %0b after the control write",
			$time, ch, level);
	end
endtask

task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
	input logic [DATA_W-1:0] act);
	if (act !== exp) begin
		n_value_err++;
		$display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
	end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		n_value_err++;
		$display("ERROR %0t ns %s expected %b actual %b", $time, name, exp, act);
	end
endtask

task automatic check_count(input string name, input logic [COUNT_W-1:0] exp,
	input logic [COUNT_W-1:0] act);
	if (act !== exp) begin
		n_value_err++;
		$display("ERROR %0t ns %s expected %0d actual %0d", $time, name, exp, act);
	end
endtask

// Samples out after each pulse, just before the next count clock rise
task automatic apply_edges(input int ch, input int n_edges, input logic [15:0] pattern,
	input logic [COUNT_W-1:0] exp_lows);
	logic [COUNT_W-1:0] lows;
	lows = '0;
	for (int e = 0; e < n_edges; e++) begin
		pulse_count_clk(ch);
		check_level($sformatf("out[%0d] edge %0d", ch, e), pattern[15-e], out[ch]);
		if (out[ch] === 1'b0) begin
			lows = lows + 1'b1;
		end
	end
	check_count($sformatf("low edges of out[%0d]", ch), exp_lows, lows);
endtask

/* tb_pit_top.sv */
// Table driven testbench for the three-channel interval timer
`timescale 1ns/1ps

module tb_pit_top
	import pit_pkg::*;
();

	localparam int NUM_STEPS = 11;

	logic                    ZCLK;
	logic                    rst_n;
	logic                    cs_n;
	logic                    rd_n;
	logic                    wr_n;
	logic [ADDR_W-1:0]       addr;
	logic [DATA_W-1:0]       d_in;
	logic [NUM_CHANNELS-1:0] count_clk;
	logic [NUM_CHANNELS-1:0] gate;
	logic [DATA_W-1:0]       d_out;
	logic [NUM_CHANNELS-1:0] out;

	int n_value_err = 0;
	int n_timeout   = 0;

	// One step of the table, pattern holds out after each edge with the first edge at bit 15
	typedef struct packed {
		logic [1:0]         ch;
		logic [2:0]         mode;
		logic [1:0]         rw;
		logic [COUNT_W-1:0] n;
		logic               prog;
		logic               latch;
		logic               gate;
		logic [4:0]         edges;
		logic [15:0]        pattern;
		logic [COUNT_W-1:0] lows;
		logic [2:0]         nrd;
		logic [31:0]        rd_bytes;
		logic [2:0]         outs;
	} step_t;

	step_t steps [NUM_STEPS];

	initial begin
		ZCLK = 1'b0;
		forever #5 ZCLK = ~ZCLK;
	end

	pit_top u_dut (
		.ZCLK      (ZCLK),
		.rst_n     (rst_n),
		.cs_n      (cs_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.addr      (addr),
		.d_in      (d_in),
		.count_clk (count_clk),
		.gate      (gate),
		.d_out     (d_out),
		.out       (out)
	);

	`include "tb_pit_tasks.svh"

	initial begin : main_seq
		step_t             st;
		logic [DATA_W-1:0] rd;

		rst_n     = 1'b0;
		cs_n      = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		addr      = '0;
		d_in      = '0;
		count_clk = '0;
		gate      = '0;

		steps = '{
			// ch, mode, rw, n, prog, latch, gate, edges
			// out pattern, low edges, reads, read bytes first at left, out pins 2..0
			'{2'd0, MODE_TERM, RW_LSB, 16'h0005, 1'b1, 1'b0, 1'b1, 5'd8,
				16'b0000_0111_0000_0000, 16'd5, 3'd0, 32'h0000_0000, 3'b001},
			'{2'd1, MODE_RATE, RW_BOTH, 16'h0004, 1'b1, 1'b0, 1'b1, 5'd13,
				16'b1110_1110_1110_1000, 16'd3, 3'd0, 32'h0000_0000, 3'b011},
			'{2'd2, MODE_SQUARE, RW_LSB, 16'h0007, 1'b1, 1'b0, 1'b1, 5'd15,
				16'b1111_0001_1110_0010, 16'd6, 3'd0, 32'h0000_0000, 3'b111},
			'{2'd2, MODE_SQUARE, RW_LSB, 16'h0006, 1'b1, 1'b0, 1'b1, 5'd13,
				16'b1110_0011_1000_1000, 16'd6, 3'd0, 32'h0000_0000, 3'b111},
			// Gate low freezes the count at its reload value
			'{2'd2, MODE_SQUARE, RW_LSB, 16'h0006, 1'b0, 1'b0, 1'b0, 5'd4,
				16'b1111_0000_0000_0000, 16'd0, 3'd1, 32'h0600_0000, 3'b111},
			'{2'd0, MODE_TERM, RW_BOTH, 16'h1234, 1'b1, 1'b0, 1'b0, 5'd1,
				16'b0000_0000_0000_0000, 16'd1, 3'd2, 32'h3412_0000, 3'b110},
			// Latched value first, then the live count
			'{2'd0, MODE_TERM, RW_BOTH, 16'h1234, 1'b0, 1'b1, 1'b1, 5'd3,
				16'b0000_0000_0000_0000, 16'd3, 3'd4, 32'h3412_3112, 3'b110},
			'{2'd1, MODE_RATE, RW_LSB, 16'h0003, 1'b1, 1'b0, 1'b1, 5'd7,
				16'b1101_1010_0000_0000, 16'd2, 3'd1, 32'h0300_0000, 3'b110},
			'{2'd2, MODE_TERM, RW_MSB, 16'h0200, 1'b1, 1'b0, 1'b1, 5'd2,
				16'b0000_0000_0000_0000, 16'd2, 3'd1, 32'h0100_0000, 3'b010},
			// Other channels untouched by the writes above
			'{2'd0, MODE_TERM, RW_BOTH, 16'h1234, 1'b0, 1'b0, 1'b1, 5'd0,
				16'b0000_0000_0000_0000, 16'd0, 3'd2, 32'h3112_0000, 3'b010},
			'{2'd1, MODE_RATE, RW_LSB, 16'h0003, 1'b0, 1'b0, 1'b1, 5'd0,
				16'b0000_0000_0000_0000, 16'd0, 3'd1, 32'h0300_0000, 3'b010}
		};

		repeat (2) @(posedge ZCLK);
		#1;
		rst_n = 1'b1;

		check_byte("d_out after reset", '0, d_out);
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			check_level($sformatf("out[%0d] after reset", c), 1'b0, out[c]);
		end

		for (int i = 0; i < NUM_STEPS; i++) begin
			st = steps[i];
			if (st.prog) begin
				write_control(st.ch, st.mode, st.rw);
				wait_out_level(st.ch, st.mode != MODE_TERM, 4);
				write_count(st.ch, st.rw, st.n);
			end
			if (st.latch) begin
				latch_count(st.ch);
			end
			gate[st.ch] = st.gate;
			if (st.edges != '0) begin
				apply_edges(st.ch, st.edges, st.pattern, st.lows);
			end
			for (int k = 0; k < st.nrd; k++) begin
				bus_read(st.ch, rd);
				check_byte($sformatf("d_out step %0d read %0d", i, k),
					st.rd_bytes[31-8*k -: 8], rd);
			end
			for (int c = 0; c < NUM_CHANNELS; c++) begin
				check_level($sformatf("out[%0d] end of step %0d", c, i), st.outs[c], out[c]);
			end
		end

		$display("Done with %0d value errors and %0d timeouts", n_value_err, n_timeout);
		if (n_value_err == 0 && n_timeout == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* pit8253.f */
+incdir+.
pit_pkg.sv
pit_bus_decode.sv
pit_channel.sv
pit_read_collect.sv
pit_top.sv
tb_pit_top.sv

/* Bender.yml */
package:
  name: pit8253

sources:
  - pit_pkg.sv
  - pit_bus_decode.sv
  - pit_channel.sv
  - pit_read_collect.sv
  - pit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pit_top.sv
